// ==== src/rv_consts.svh ====
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

`default_nettype none

// datapath and register index widths
`define XLEN        32
`define REG_ADDR_W  5

// reset vector and the bubble word (addi x0 x0 0)
`define RESET_PC    32'h0000_0000
`define NOP_INSTR   32'h0000_0013

// major opcodes of the supported subset
`define OPC_RTYPE   7'b0110011
`define OPC_ADDI    7'b0010011
`define OPC_LOAD    7'b0000011
`define OPC_STORE   7'b0100011
`define OPC_BRANCH  7'b1100011
`define OPC_JAL     7'b1101111

// funct3 codes
`define F3_ADD      3'b000
`define F3_SLT      3'b010
`define F3_XOR      3'b100
`define F3_OR       3'b110
`define F3_AND      3'b111
`define F3_WORD     3'b010
`define F3_BEQ      3'b000

// funct7 that turns add into sub
`define F7_SUB      7'b0100000

`default_nettype wire

`endif

// ==== src/rv_pkg.sv ====
`include "rv_consts.svh"

`default_nettype none

package rv_pkg;

	//////////////////////////////////////////////////////////////////////
	// instruction word views
	//////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic [6:0]             funct7;
		logic [`REG_ADDR_W-1:0] rs2;
		logic [`REG_ADDR_W-1:0] rs1;
		logic [2:0]             funct3;
		logic [`REG_ADDR_W-1:0] rd;
		logic [6:0]             opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0]            imm;
		logic [`REG_ADDR_W-1:0] rs1;
		logic [2:0]             funct3;
		logic [`REG_ADDR_W-1:0] rd;
		logic [6:0]             opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0]             imm_hi;
		logic [`REG_ADDR_W-1:0] rs2;
		logic [`REG_ADDR_W-1:0] rs1;
		logic [2:0]             funct3;
		logic [4:0]             imm_lo;
		logic [6:0]             opcode;
	} s_fmt_t;

	// branch offset bits are scattered over the word
	typedef struct packed {
		logic                   imm_12;
		logic [5:0]             imm_10_5;
		logic [`REG_ADDR_W-1:0] rs2;
		logic [`REG_ADDR_W-1:0] rs1;
		logic [2:0]             funct3;
		logic [3:0]             imm_4_1;
		logic                   imm_11;
		logic [6:0]             opcode;
	} b_fmt_t;

	typedef struct packed {
		logic                   imm_20;
		logic [9:0]             imm_10_1;
		logic                   imm_11;
		logic [7:0]             imm_19_12;
		logic [`REG_ADDR_W-1:0] rd;
		logic [6:0]             opcode;
	} j_fmt_t;

	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		s_fmt_t s;
		b_fmt_t b;
		j_fmt_t j;
	} instr_t;

	//////////////////////////////////////////////////////////////////////
	// control and pipeline registers
	//////////////////////////////////////////////////////////////////////

	typedef enum logic [3:0] {ADD, SUB, AND, OR, XOR, SLT} alu_op_t;

	typedef enum logic [1:0] {REGFILE, FROM_EXMEM, FROM_MEMWB} fwd_sel_t;

	typedef struct packed {
		logic    reg_write;
		logic    mem_read;
		logic    mem_write;
		logic    mem_to_reg;
		logic    alu_src_imm;
		logic    branch;
		logic    jump;
		alu_op_t alu_op;
	} ctrl_t;

	typedef struct packed {
		ctrl_t                  ctrl;
		logic [`XLEN-1:0]       pc;
		logic [`XLEN-1:0]       rs1_data;
		logic [`XLEN-1:0]       rs2_data;
		logic [`XLEN-1:0]       imm;
		logic [`REG_ADDR_W-1:0] rs1;
		logic [`REG_ADDR_W-1:0] rs2;
		logic [`REG_ADDR_W-1:0] rd;
	} id_ex_t;

	typedef struct packed {
		logic                   reg_write;
		logic                   mem_read;
		logic                   mem_write;
		logic                   mem_to_reg;
		logic                   branch;
		logic [`XLEN-1:0]       alu_result;
		logic [`XLEN-1:0]       store_data;
		logic [`XLEN-1:0]       branch_target;
		logic                   zero;
		logic [`REG_ADDR_W-1:0] rd;
	} ex_mem_t;

	// load data is captured beside this register in the core
	typedef struct packed {
		logic                   reg_write;
		logic                   mem_to_reg;
		logic [`XLEN-1:0]       alu_result;
		logic [`REG_ADDR_W-1:0] rd;
	} mem_wb_t;

endpackage

`default_nettype wire

// ==== src/rv_decode.sv ====
`timescale 1ns/1ps
`include "rv_consts.svh"

`default_nettype none

module rv_decode (
	input  wire rv_pkg::instr_t instr,
	output rv_pkg::ctrl_t       ctrl,
	output logic [`XLEN-1:0]    imm
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;

	assign opcode = instr.r.opcode;
	assign funct3 = instr.r.funct3;
	assign funct7 = instr.r.funct7;

	// main control, anything unrecognised stays an all-zero no-write word
	always_comb begin
		ctrl = '0;
		case (opcode)
			`OPC_RTYPE: begin
				ctrl.reg_write = (funct7 == 7'b0) ||
					(funct7 == `F7_SUB && funct3 == `F3_ADD);
				case (funct3)
					`F3_ADD: ctrl.alu_op = (funct7 == `F7_SUB) ? rv_pkg::SUB : rv_pkg::ADD;
					`F3_SLT: ctrl.alu_op = rv_pkg::SLT;
					`F3_XOR: ctrl.alu_op = rv_pkg::XOR;
					`F3_OR:  ctrl.alu_op = rv_pkg::OR;
					`F3_AND: ctrl.alu_op = rv_pkg::AND;
					default: ctrl.reg_write = 1'b0;
				endcase
			end
			`OPC_ADDI: begin
				ctrl.reg_write   = (funct3 == `F3_ADD);
				ctrl.alu_src_imm = 1'b1;
			end
			`OPC_LOAD: begin
				ctrl.reg_write   = (funct3 == `F3_WORD);
				ctrl.mem_read    = (funct3 == `F3_WORD);
				ctrl.mem_to_reg  = 1'b1;
				ctrl.alu_src_imm = 1'b1;
			end
			`OPC_STORE: begin
				ctrl.mem_write   = (funct3 == `F3_WORD);
				ctrl.alu_src_imm = 1'b1;
			end
			`OPC_BRANCH: begin
				// equality through the subtract result
				ctrl.branch = (funct3 == `F3_BEQ);
				ctrl.alu_op = rv_pkg::SUB;
			end
			`OPC_JAL: begin
				ctrl.reg_write = 1'b1;
				ctrl.jump      = 1'b1;
			end
			default: ctrl = '0;
		endcase
	end

	// sign-extended immediates
	always_comb begin
		case (opcode)
			`OPC_ADDI, `OPC_LOAD:
				imm = {{(`XLEN-12){instr.i.imm[11]}}, instr.i.imm};
			`OPC_STORE:
				imm = {{(`XLEN-12){instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
			`OPC_BRANCH:
				imm = {{(`XLEN-12){instr.b.imm_12}}, instr.b.imm_11,
					instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
			`OPC_JAL:
				imm = {{(`XLEN-20){instr.j.imm_20}}, instr.j.imm_19_12,
					instr.j.imm_11, instr.j.imm_10_1, 1'b0};
			default:
				imm = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== src/rv_regfile.sv ====
`timescale 1ns/1ps
`include "rv_consts.svh"

`default_nettype none

module rv_regfile (
	input  wire                   clock,
	input  wire                   reset,
	input  wire [`REG_ADDR_W-1:0] rs1,
	input  wire [`REG_ADDR_W-1:0] rs2,
	output logic [`XLEN-1:0]      rs1_data,
	output logic [`XLEN-1:0]      rs2_data,
	input  wire [`REG_ADDR_W-1:0] rd,
	input  wire [`XLEN-1:0]       rd_data,
	input  wire                   write_en
);

	// x0 has no storage
	logic [`XLEN-1:0] regs [1:31];

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end else if (write_en && rd != '0) begin
			regs[rd] <= rd_data;
		end
	end

	// write-through so ID sees the value WB is writing
	function automatic logic [`XLEN-1:0] read_port(input logic [`REG_ADDR_W-1:0] idx);
		if (idx == '0)
			return '0;
		else if (write_en && rd == idx)
			return rd_data;
		else
			return regs[idx];
	endfunction

	always_comb begin
		rs1_data = read_port(rs1);
		rs2_data = read_port(rs2);
	end

	// a write reads back on the next cycle, and one aimed at x0 reads back as zero
	assert property (@(posedge clock) disable iff (!reset)
		write_en |=> rs1 != $past(rd) || (write_en && rd == rs1) ||
			rs1_data == ($past(rd) == '0 ? '0 : $past(rd_data)))
		else $error("register write not read back as written");

endmodule

`default_nettype wire

// ==== src/rv_hazard.sv ====
`timescale 1ns/1ps
`include "rv_consts.svh"

`default_nettype none

module rv_hazard (
	input  wire                   clock,
	input  wire                   reset,
	input  wire [`REG_ADDR_W-1:0] id_rs1,
	input  wire [`REG_ADDR_W-1:0] id_rs2,
	input  wire                   id_jump,
	input  wire rv_pkg::id_ex_t   id_ex,
	input  wire rv_pkg::ex_mem_t  ex_mem,
	input  wire rv_pkg::mem_wb_t  mem_wb,
	output logic                  stall,
	output logic                  flush_ifid,
	output logic                  flush_idex,
	output logic                  flush_exmem,
	output rv_pkg::fwd_sel_t      fwd_a,
	output rv_pkg::fwd_sel_t      fwd_b,
	output logic                  branch_taken
);

	logic load_use;

	assign branch_taken = ex_mem.branch && ex_mem.zero;

	// load in EX whose result the ID instruction needs
	assign load_use = id_ex.ctrl.mem_read && id_ex.rd != '0 &&
		(id_ex.rd == id_rs1 || id_ex.rd == id_rs2);

	// branch wins over jump, jump over stall
	assign stall       = load_use && !branch_taken && !id_jump;
	assign flush_ifid  = branch_taken || id_jump;
	assign flush_idex  = branch_taken || stall;
	assign flush_exmem = branch_taken;

	// newest producer first
	function automatic rv_pkg::fwd_sel_t pick(input logic [`REG_ADDR_W-1:0] src);
		if (ex_mem.reg_write && ex_mem.rd != '0 && ex_mem.rd == src)
			return rv_pkg::FROM_EXMEM;
		else if (mem_wb.reg_write && mem_wb.rd != '0 && mem_wb.rd == src)
			return rv_pkg::FROM_MEMWB;
		else
			return rv_pkg::REGFILE;
	endfunction

	always_comb begin
		fwd_a = pick(id_ex.rs1);
		fwd_b = pick(id_ex.rs2);
	end

	// the bubble behind a load-use stall clears it the next cycle
	assert property (@(posedge clock) disable iff (!reset)
		stall |=> !stall)
		else $error("load-use stall held for more than one cycle");

	// the stall keeps a load out of the EX/MEM forward path
	assert property (@(posedge clock) disable iff (!reset)
		(!id_ex.ctrl.jump &&
			(fwd_a == rv_pkg::FROM_EXMEM || fwd_b == rv_pkg::FROM_EXMEM))
			|-> !ex_mem.mem_read)
		else $error("load address forwarded from EX/MEM as data");

endmodule

`default_nettype wire

// ==== src/rv_execute.sv ====
`timescale 1ns/1ps
`include "rv_consts.svh"

`default_nettype none

module rv_execute (
	input  wire rv_pkg::id_ex_t   id_ex,
	input  wire rv_pkg::fwd_sel_t fwd_a,
	input  wire rv_pkg::fwd_sel_t fwd_b,
	input  wire [`XLEN-1:0]       exmem_result,
	input  wire [`XLEN-1:0]       wb_result,
	output logic [`XLEN-1:0]      result,
	output logic                  zero,
	output logic [`XLEN-1:0]      store_data,
	output logic [`XLEN-1:0]      branch_target
);

	localparam logic [`XLEN-1:0] instr_bytes = 4;

	logic [`XLEN-1:0] op_a;
	logic [`XLEN-1:0] op_b;
	logic [`XLEN-1:0] alu_out;
	logic             less;

	function automatic logic [`XLEN-1:0] bypass(
		input rv_pkg::fwd_sel_t sel,
		input logic [`XLEN-1:0] reg_value,
		input logic [`XLEN-1:0] mem_value,
		input logic [`XLEN-1:0] wb_value
	);
		case (sel)
			rv_pkg::FROM_EXMEM: return mem_value;
			rv_pkg::FROM_MEMWB: return wb_value;
			default:            return reg_value;
		endcase
	endfunction

	assign op_a       = bypass(fwd_a, id_ex.rs1_data, exmem_result, wb_result);
	assign store_data = bypass(fwd_b, id_ex.rs2_data, exmem_result, wb_result);
	assign op_b       = id_ex.ctrl.alu_src_imm ? id_ex.imm : store_data;

	assign less = $signed(op_a) < $signed(op_b);

	always_comb begin
		case (id_ex.ctrl.alu_op)
			rv_pkg::ADD: alu_out = op_a + op_b;
			rv_pkg::SUB: alu_out = op_a - op_b;
			rv_pkg::AND: alu_out = op_a & op_b;
			rv_pkg::OR:  alu_out = op_a | op_b;
			rv_pkg::XOR: alu_out = op_a ^ op_b;
			rv_pkg::SLT: alu_out = {{(`XLEN-1){1'b0}}, less};
			default:     alu_out = '0;
		endcase
	end

	// beq looks at the subtract result
	assign zero = (alu_out == '0);

	// jal writes its return address
	assign result        = id_ex.ctrl.jump ? id_ex.pc + instr_bytes : alu_out;
	assign branch_target = id_ex.pc + id_ex.imm;

endmodule

`default_nettype wire

// ==== src/rv_core.sv ====
`timescale 1ns/1ps
`include "rv_consts.svh"

`default_nettype none

module rv_core (
	input  wire                 clock,
	input  wire                 reset,
	output logic [`XLEN-1:0]    pc,
	input  wire rv_pkg::instr_t instr,
	output logic [`XLEN-1:0]    data_addr,
	output logic                rd_en,
	output logic                wr_en,
	output logic [`XLEN-1:0]    wr_data,
	input  wire [`XLEN-1:0]     rd_data
);

	localparam logic [`XLEN-1:0] instr_bytes = 4;

	rv_pkg::instr_t   if_id_instr;
	logic [`XLEN-1:0] if_id_pc;
	rv_pkg::id_ex_t   id_ex;
	rv_pkg::ex_mem_t  ex_mem;
	rv_pkg::mem_wb_t  mem_wb;
	logic [`XLEN-1:0] wb_load_data;

	rv_pkg::ctrl_t    id_ctrl;
	logic [`XLEN-1:0] id_imm;
	logic [`XLEN-1:0] id_rs1_data;
	logic [`XLEN-1:0] id_rs2_data;

	logic             stall;
	logic             flush_ifid;
	logic             flush_idex;
	logic             flush_exmem;
	logic             branch_taken;
	rv_pkg::fwd_sel_t fwd_a;
	rv_pkg::fwd_sel_t fwd_b;

	logic [`XLEN-1:0] ex_result;
	logic             ex_zero;
	logic [`XLEN-1:0] ex_store_data;
	logic [`XLEN-1:0] ex_branch_target;
	logic [`XLEN-1:0] wb_result;
	logic [`XLEN-1:0] next_pc;

	//////////////////////////////////////////////////////////////////////
	// fetch
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		if (branch_taken)
			next_pc = ex_mem.branch_target;
		else if (id_ctrl.jump)
			next_pc = if_id_pc + id_imm;
		else if (stall)
			next_pc = pc;
		else
			next_pc = pc + instr_bytes;
	end

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			pc          <= `RESET_PC;
			if_id_pc    <= `RESET_PC;
			if_id_instr <= `NOP_INSTR;
		end else begin
			pc <= next_pc;
			if (flush_ifid || !stall) begin
				if_id_pc    <= pc;
				if_id_instr <= flush_ifid ? rv_pkg::instr_t'(`NOP_INSTR) : instr;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// decode
	//////////////////////////////////////////////////////////////////////

	rv_decode rv_decode_inst (
		.instr (if_id_instr),
		.ctrl  (id_ctrl),
		.imm   (id_imm)
	);

	rv_regfile rv_regfile_inst (
		.clock    (clock),
		.reset    (reset),
		.rs1      (if_id_instr.r.rs1),
		.rs2      (if_id_instr.r.rs2),
		.rs1_data (id_rs1_data),
		.rs2_data (id_rs2_data),
		.rd       (mem_wb.rd),
		.rd_data  (wb_result),
		.write_en (mem_wb.reg_write)
	);

	rv_hazard rv_hazard_inst (
		.clock        (clock),
		.reset        (reset),
		.id_rs1       (if_id_instr.r.rs1),
		.id_rs2       (if_id_instr.r.rs2),
		.id_jump      (id_ctrl.jump),
		.id_ex        (id_ex),
		.ex_mem       (ex_mem),
		.mem_wb       (mem_wb),
		.stall        (stall),
		.flush_ifid   (flush_ifid),
		.flush_idex   (flush_idex),
		.flush_exmem  (flush_exmem),
		.fwd_a        (fwd_a),
		.fwd_b        (fwd_b),
		.branch_taken (branch_taken)
	);

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			id_ex <= '0;
		end else if (flush_idex) begin
			id_ex <= '0;
		end else begin
			id_ex.ctrl     <= id_ctrl;
			id_ex.pc       <= if_id_pc;
			id_ex.rs1_data <= id_rs1_data;
			id_ex.rs2_data <= id_rs2_data;
			id_ex.imm      <= id_imm;
			id_ex.rs1      <= if_id_instr.r.rs1;
			id_ex.rs2      <= if_id_instr.r.rs2;
			id_ex.rd       <= if_id_instr.r.rd;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// execute
	//////////////////////////////////////////////////////////////////////

	rv_execute rv_execute_inst (
		.id_ex         (id_ex),
		.fwd_a         (fwd_a),
		.fwd_b         (fwd_b),
		.exmem_result  (ex_mem.alu_result),
		.wb_result     (wb_result),
		.result        (ex_result),
		.zero          (ex_zero),
		.store_data    (ex_store_data),
		.branch_target (ex_branch_target)
	);

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			ex_mem <= '0;
		end else if (flush_exmem) begin
			ex_mem <= '0;
		end else begin
			ex_mem.reg_write     <= id_ex.ctrl.reg_write;
			ex_mem.mem_read      <= id_ex.ctrl.mem_read;
			ex_mem.mem_write     <= id_ex.ctrl.mem_write;
			ex_mem.mem_to_reg    <= id_ex.ctrl.mem_to_reg;
			ex_mem.branch        <= id_ex.ctrl.branch;
			ex_mem.alu_result    <= ex_result;
			ex_mem.store_data    <= ex_store_data;
			ex_mem.branch_target <= ex_branch_target;
			ex_mem.zero          <= ex_zero;
			ex_mem.rd            <= id_ex.rd;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// memory and writeback
	//////////////////////////////////////////////////////////////////////

	// the read is issued from EX so the data is back while the load is in MEM
	assign rd_en     = id_ex.ctrl.mem_read && !branch_taken;
	assign data_addr = rd_en ? ex_result : ex_mem.alu_result;
	assign wr_en     = ex_mem.mem_write;
	assign wr_data   = ex_mem.store_data;

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			mem_wb <= '0;
		end else begin
			mem_wb.reg_write  <= ex_mem.reg_write;
			mem_wb.mem_to_reg <= ex_mem.mem_to_reg;
			mem_wb.alu_result <= ex_mem.alu_result;
			mem_wb.rd         <= ex_mem.rd;
		end
	end

	always_ff @(posedge clock) begin
		if (ex_mem.mem_read)
			wb_load_data <= rd_data;
	end

	assign wb_result = mem_wb.mem_to_reg ? wb_load_data : mem_wb.alu_result;

endmodule

`default_nettype wire

// ==== verif/rv_core_tb.sv ====
`timescale 1ns/1ps
`include "rv_consts.svh"

`default_nettype none

module rv_core_tb;

	localparam int IMEM_WORDS  = 1024;
	localparam int DMEM_WORDS  = 256;
	localparam int BLOCKS      = 36;
	localparam int CYCLE_LIMIT = 5000;
	localparam int MODEL_STEPS = 10000;

	logic                 clock;
	logic                 reset;
	logic [`XLEN-1:0]     pc;
	rv_pkg::instr_t       instr;
	logic [`XLEN-1:0]     data_addr;
	logic                 rd_en;
	logic                 wr_en;
	logic [`XLEN-1:0]     wr_data;
	logic [`XLEN-1:0]     rd_data;

	logic [31:0] imem [IMEM_WORDS];
	logic [31:0] dmem [DMEM_WORDS];
	logic [31:0] model_mem [DMEM_WORDS];
	logic [31:0] model_regs [32];
	logic [31:0] exp_addr [$];
	logic [31:0] exp_data [$];

	logic [31:0] lfsr;
	logic [31:0] halt_pc;
	logic        last_store;
	int          n_instr;
	int          exp_total;
	int          stores_seen;
	int          errors;
	int          checks;

	rv_core rv_core_inst (
		.clock     (clock),
		.reset     (reset),
		.pc        (pc),
		.instr     (instr),
		.data_addr (data_addr),
		.rd_en     (rd_en),
		.wr_en     (wr_en),
		.wr_data   (wr_data),
		.rd_data   (rd_data)
	);

	// instruction memory answers in the same cycle
	assign instr = rv_pkg::instr_t'(imem[pc[11:2]]);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	//////////////////////////////////////////////////////////////////////
	// stimulus helpers
	//////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// one LFSR step per bit
	function automatic logic [31:0] draw(input int nbits);
		logic [31:0] v;
		v = '0;
		for (int k = 0; k < nbits; k++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic logic [31:0] fill_word(input int idx);
		return (32'(idx) * 32'h0100_0193) ^ 32'h5bd1_e995;
	endfunction

	function automatic logic [4:0] pick_reg();
		return 5'(1 + draw(3) % 7);
	endfunction

	function automatic logic [11:0] word_offset();
		return 12'(draw(8) * 4);
	endfunction

	function automatic logic [31:0] rtype_word(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, `OPC_RTYPE};
	endfunction

	function automatic logic [31:0] itype_word(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	// loads and stores are all based on x0
	function automatic logic [31:0] store_word(input logic [4:0] rs2, input logic [11:0] imm);
		return {imm[11:5], rs2, 5'd0, `F3_WORD, imm[4:0], `OPC_STORE};
	endfunction

	function automatic logic [31:0] load_word(input logic [4:0] rd, input logic [11:0] imm);
		return itype_word(imm, 5'd0, `F3_WORD, rd, `OPC_LOAD);
	endfunction

	function automatic logic [31:0] branch_word(input logic [4:0] rs1, input logic [4:0] rs2,
		input logic [12:0] off);
		return {off[12], off[10:5], rs2, rs1, `F3_BEQ, off[4:1], off[11], `OPC_BRANCH};
	endfunction

	function automatic logic [31:0] jal_word(input logic [4:0] rd, input logic [20:0] off);
		return {off[20], off[10:1], off[11], off[19:12], rd, `OPC_JAL};
	endfunction

	function automatic logic [31:0] alu_word(input logic [4:0] rd, input logic [4:0] rs1,
		input logic [4:0] rs2);
		logic [2:0]  sel;
		logic [11:0] imm;
		sel = 3'(draw(3));
		imm = 12'(draw(12));
		case (sel)
			3'd0:    return rtype_word(7'd0, rs2, rs1, `F3_ADD, rd);
			3'd1:    return rtype_word(`F7_SUB, rs2, rs1, `F3_ADD, rd);
			3'd2:    return rtype_word(7'd0, rs2, rs1, `F3_AND, rd);
			3'd3:    return rtype_word(7'd0, rs2, rs1, `F3_OR, rd);
			3'd4:    return rtype_word(7'd0, rs2, rs1, `F3_XOR, rd);
			3'd5:    return rtype_word(7'd0, rs2, rs1, `F3_SLT, rd);
			default: return itype_word(imm, rs1, `F3_ADD, rd, `OPC_ADDI);
		endcase
	endfunction

	// a nop keeps a load from sitting in EX while a store is in MEM
	function automatic void emit(input logic [31:0] w);
		if (w[6:0] == `OPC_LOAD && last_store) begin
			imem[n_instr] = `NOP_INSTR;
			n_instr++;
		end
		imem[n_instr] = w;
		n_instr++;
		last_store = (w[6:0] == `OPC_STORE);
	endfunction

	task automatic build_program();
		logic [4:0] ra;
		logic [4:0] rb;
		logic [4:0] rc;
		int         len;
		n_instr = 0;
		last_store = 1'b0;
		for (int i = 0; i < IMEM_WORDS; i++)
			imem[i] = `NOP_INSTR;
		for (int blk = 0; blk < BLOCKS; blk++) begin
			case (blk % 6)
				0: begin
					// dependent chain, each op reads the previous result
					len = 2 + int'(draw(2));
					ra = pick_reg();
					for (int k = 0; k < len; k++) begin
						rb = pick_reg();
						rc = pick_reg();
						emit(alu_word(rc, ra, rb));
						ra = rc;
					end
					emit(store_word(ra, word_offset()));
				end
				1: begin
					ra = pick_reg();
					rb = pick_reg();
					rc = pick_reg();
					emit(load_word(ra, word_offset()));
					emit(rtype_word(7'd0, rc, ra, `F3_ADD, rb));
					emit(store_word(rb, word_offset()));
				end
				2: begin
					ra = pick_reg();
					emit(branch_word(ra, ra, 13'd16));
					for (int k = 0; k < 3; k++)
						emit(store_word(pick_reg(), word_offset()));
				end
				3: begin
					emit(itype_word(12'(1 + draw(10)), 5'd0, `F3_ADD, 5'd8, `OPC_ADDI));
					emit(branch_word(5'd8, 5'd0, 13'd16));
					for (int k = 0; k < 3; k++)
						emit(store_word(pick_reg(), word_offset()));
				end
				4: begin
					ra = pick_reg();
					emit(jal_word(ra, 21'd8));
					emit(store_word(pick_reg(), word_offset()));
					emit(store_word(ra, word_offset()));
				end
				default: begin
					emit(itype_word(12'(draw(12)), pick_reg(), `F3_ADD, 5'd0, `OPC_ADDI));
					emit(rtype_word(7'd0, pick_reg(), pick_reg(), `F3_OR, 5'd0));
					emit(store_word(5'd0, word_offset()));
				end
			endcase
		end
		// spin on a jump to itself
		halt_pc = 32'(n_instr * 4);
		emit(jal_word(5'd0, 21'd0));
	endtask

	//////////////////////////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////////////////////////

	task automatic run_model();
		logic [31:0] mpc;
		logic [31:0] next;
		logic [31:0] w;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] res;
		logic [31:0] addr;
		logic [31:0] imm_i;
		logic [31:0] imm_s;
		logic [31:0] imm_b;
		logic [31:0] imm_j;
		int          steps;
		for (int i = 0; i < 32; i++)
			model_regs[i] = '0;
		mpc = `RESET_PC;
		steps = 0;
		while (mpc != halt_pc && steps < MODEL_STEPS) begin
			w = imem[mpc[11:2]];
			a = model_regs[w[19:15]];
			b = model_regs[w[24:20]];
			imm_i = {{20{w[31]}}, w[31:20]};
			imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
			imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
			imm_j = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
			next = mpc + 4;
			case (w[6:0])
				`OPC_RTYPE: begin
					case (w[14:12])
						`F3_ADD: res = w[30] ? a - b : a + b;
						`F3_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						`F3_XOR: res = a ^ b;
						`F3_OR:  res = a | b;
						default: res = a & b;
					endcase
					model_regs[w[11:7]] = res;
				end
				`OPC_ADDI:
					model_regs[w[11:7]] = a + imm_i;
				`OPC_LOAD: begin
					addr = a + imm_i;
					model_regs[w[11:7]] = model_mem[addr[9:2]];
				end
				`OPC_STORE: begin
					addr = a + imm_s;
					model_mem[addr[9:2]] = b;
					exp_addr.push_back(addr);
					exp_data.push_back(b);
				end
				`OPC_BRANCH:
					if (a == b)
						next = mpc + imm_b;
				default: begin
					model_regs[w[11:7]] = mpc + 4;
					next = mpc + imm_j;
				end
			endcase
			model_regs[0] = '0;
			mpc = next;
			steps++;
		end
		if (mpc != halt_pc) begin
			errors++;
			$display("reference model never reached the halt loop");
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////////////////////////

	task automatic check_reset_state();
		checks += 3;
		assert (pc == `RESET_PC) else begin
			errors++;
			$display("error reset_pc expected %h actual %h", `RESET_PC, pc);
		end
		assert (!rd_en) else begin
			errors++;
			$display("error reset_rd_en expected 0 actual %b", rd_en);
		end
		assert (!wr_en) else begin
			errors++;
			$display("error reset_wr_en expected 0 actual %b", wr_en);
		end
	endtask

	task automatic check_store(input logic [31:0] addr, input logic [31:0] data);
		checks++;
		assert (exp_addr.size() != 0) else begin
			errors++;
			$display("store of %h to %h came after the expected stores ran out", data, addr);
		end
		if (exp_addr.size() != 0) begin
			checks += 2;
			assert (addr == exp_addr[0]) else begin
				errors++;
				$display("error store_addr_%0d expected %h actual %h",
					stores_seen, exp_addr[0], addr);
			end
			assert (data == exp_data[0]) else begin
				errors++;
				$display("error store_data_%0d expected %h actual %h",
					stores_seen, exp_data[0], data);
			end
			void'(exp_addr.pop_front());
			void'(exp_data.pop_front());
			stores_seen++;
		end
	endtask

	// data memory, read registered from EX, write from MEM
	initial begin
		logic        s_rd;
		logic        s_wr;
		logic [31:0] s_addr;
		logic [31:0] s_wdata;
		rd_data = '0;
		forever begin
			@(negedge clock);
			s_rd = rd_en;
			s_wr = wr_en;
			s_addr = data_addr;
			s_wdata = wr_data;
			if (s_wr)
				check_store(s_addr, s_wdata);
			@(posedge clock);
			#1;
			if (s_rd)
				rd_data = dmem[s_addr[9:2]];
			if (s_wr)
				dmem[s_addr[9:2]] = s_wdata;
		end
	end

	initial begin
		int cycles;
		errors = 0;
		checks = 0;
		stores_seen = 0;
		reset = 1'b0;
		lfsr = 32'hd849_1960;
		for (int i = 0; i < DMEM_WORDS; i++) begin
			dmem[i] = fill_word(i);
			model_mem[i] = fill_word(i);
		end
		build_program();
		run_model();
		exp_total = exp_addr.size();

		for (int i = 0; i < 16; i++) begin
			@(negedge clock);
			check_reset_state();
		end
		@(posedge clock);
		#1;
		reset = 1'b1;
		@(negedge clock);
		check_reset_state();

		cycles = 0;
		while ((stores_seen < exp_total || pc != halt_pc) && cycles < CYCLE_LIMIT) begin
			@(negedge clock);
			cycles++;
		end
		if (cycles >= CYCLE_LIMIT) begin
			errors++;
			$display("timeout: program did not finish within %0d cycles", CYCLE_LIMIT);
		end

		// any late store shows up in the monitor
		for (int i = 0; i < 20; i++)
			@(negedge clock);

		$display("checks %0d, stores %0d of %0d, errors %0d",
			checks, stores_seen, exp_total, errors);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+src
src/rv_pkg.sv
src/rv_decode.sv
src/rv_regfile.sv
src/rv_hazard.sv
src/rv_execute.sv
src/rv_core.sv
verif/rv_core_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the rv_core testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

log_file=sim.log

verilator --binary --assert -Wno-fatal --top-module rv_core_tb \
	-f sim.f -o rv_core_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/rv_core_sim > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -q "Simulation finished: FAIL" "$log_file"; then
	exit 1
fi
if ! grep -q "Simulation finished: PASS" "$log_file"; then
	echo "no pass line found in $log_file"
	exit 1
fi
exit 0
